// File: Bender.yml
package:
  name: vlb

sources:
  - hw/vlb_pkg.sv
  - hw/slot_ctrl_parser.sv
  - hw/queue_snapshot.sv
  - hw/relay_route_table.sv
  - hw/relay_allocator.sv
  - hw/vlb_top.sv
  - target: simulation
    files:
      - dv/vlb_tb.sv

// File: compile.f
hw/vlb_pkg.sv
hw/slot_ctrl_parser.sv
hw/queue_snapshot.sv
hw/relay_route_table.sv
hw/relay_allocator.sv
hw/vlb_top.sv
dv/vlb_tb.sv

// File: dv/vlb_tb.sv
`timescale 1ns/1ns

module vlb_tb;

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_ctrl_valid;
    logic [vlb_pkg::ctrl_w-1:0] i_ctrl_data;
    logic                       i_ctrl_last;
    logic [vlb_pkg::keep_w-1:0] i_ctrl_keep;
    logic                       i_ctrl_user;
    logic                       i_check_queue_resp_ready;
    vlb_pkg::size_vec_t         i_local_queue_size;
    vlb_pkg::size_vec_t         i_unlocal_queue_size;
    logic                       o_check_queue_req_valid;
    vlb_pkg::size_vec_t         i_offer0;
    vlb_pkg::size_t             i_offer0_cap;
    logic                       i_offer0_valid;
    vlb_pkg::size_vec_t         o_relay0;
    logic                       o_relay0_valid;
    vlb_pkg::size_vec_t         i_offer1;
    vlb_pkg::size_t             i_offer1_cap;
    logic                       i_offer1_valid;
    vlb_pkg::size_vec_t         o_relay1;
    logic                       o_relay1_valid;
    logic                       o_slot_start;
    vlb_pkg::slot_t             o_slot_id;

    logic [31:0]        lfsr = 32'hdfe6;
    vlb_pkg::size_vec_t model_avail;
    vlb_pkg::size_vec_t exp0 [$];
    vlb_pkg::size_vec_t exp1 [$];
    vlb_pkg::size_vec_t got_exp;
    int                 cur_slot;
    int                 errors;
    int                 checks;
    int                 cases;
    int                 case_err_start;
    int                 slot_start_cnt;
    int                 relay0_cnt;
    int                 relay1_cnt;

    vlb_top dut_i (.*);

    always #2 i_clk = ~i_clk;

    //////////////////////////////
    // random source and model
    //////////////////////////////
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic vlb_pkg::size_t smaller(input vlb_pkg::size_t x, input vlb_pkg::size_t y);
        return (x < y) ? x : y;
    endfunction

    // neighbors reached in the slot after cur
    function automatic vlb_pkg::tor_t neighbor(input int cur, input bit odd);
        int nx;
        int n;
        nx = (cur + 1) % vlb_pkg::slot_num;
        if (odd) begin
            n = int'(vlb_pkg::my_tor_id) - 2 * nx - 1;
        end else begin
            n = int'(vlb_pkg::my_tor_id) + 2 * nx + 1;
        end
        n = ((n % int'(vlb_pkg::tor_num)) + int'(vlb_pkg::tor_num)) % int'(vlb_pkg::tor_num);
        return vlb_pkg::tor_t'(n);
    endfunction

    function automatic vlb_pkg::size_vec_t relay_grant(input vlb_pkg::size_vec_t avail,
                                                       input vlb_pkg::tor_t n0,
                                                       input vlb_pkg::tor_t n1,
                                                       input vlb_pkg::size_vec_t offer,
                                                       input vlb_pkg::size_t cap);
        vlb_pkg::size_vec_t g;
        vlb_pkg::size_t     a;
        vlb_pkg::size_t     b;
        g = '0;
        a = smaller(smaller(offer[n0], cap), avail[n0]);
        b = smaller(smaller(offer[n1], cap - a), avail[n1]);
        g[n0] = a;
        g[n1] = b;
        return g;
    endfunction

    function automatic logic level_of(input int which);
        case (which)
            0: return o_check_queue_req_valid;
            1: return o_slot_start;
            2: return o_relay0_valid;
            default: return o_relay1_valid;
        endcase
    endfunction

    task automatic wait_level(input int which, input logic level, input int limit,
                              input string what);
        for (int n = 0; n < limit && level_of(which) !== level; n++) begin
            @(negedge i_clk);
        end
        if (level_of(which) !== level) begin
            $display("timeout at %0t while waiting for %s", $time, what);
            $display("test failed");
            $finish;
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic send_frame(input logic [15:0] ftype, input int slot);
        logic [31:0] r;
        for (int b = 0; b < 3; b++) begin
            @(negedge i_clk);
            take_bits(32, r);
            i_ctrl_valid = 1'b1;
            i_ctrl_last  = (b == 2);
            i_ctrl_data  = {r, r};
            if (b == 1) begin
                i_ctrl_data = {r, ftype, 15'h0, 1'(slot)};
            end
        end
        @(negedge i_clk);
        i_ctrl_valid = 1'b0;
        i_ctrl_last  = 1'b0;
    endtask

    // new sizes, answer the request, then reload the model
    task automatic run_snapshot(input int slot);
        logic [31:0] r;
        for (int t = 0; t < vlb_pkg::tor_num; t++) begin
            take_bits(12, r);
            i_local_queue_size[t] = r;
            take_bits(12, r);
            i_unlocal_queue_size[t] = r;
        end
        wait_level(0, 1'b1, 10, "request to rise");
        i_check_queue_resp_ready = 1'b1;
        wait_level(0, 1'b0, 20, "request to fall");
        i_check_queue_resp_ready = 1'b0;
        cur_slot = slot;
        for (int t = 0; t < vlb_pkg::tor_num; t++) begin
            model_avail[t] = vlb_pkg::slot_max_pkt - i_local_queue_size[t]
                             - i_unlocal_queue_size[t];
        end
    endtask

    task automatic make_offer(output vlb_pkg::size_vec_t o, output vlb_pkg::size_t c);
        logic [31:0] r;
        for (int t = 0; t < vlb_pkg::tor_num; t++) begin
            take_bits(19, r);
            o[t] = r;
        end
        take_bits(19, r);
        c = r;
    endtask

    task automatic charge(input vlb_pkg::size_vec_t g);
        for (int t = 0; t < vlb_pkg::tor_num; t++) begin
            model_avail[t] = model_avail[t] - g[t];
        end
    endtask

    // uplink 0 is served first when both pulse together
    task automatic pulse_offers(input bit use0, input bit use1);
        vlb_pkg::size_vec_t g;
        @(negedge i_clk);
        if (use0) begin
            make_offer(i_offer0, i_offer0_cap);
            g = relay_grant(model_avail, neighbor(cur_slot, 0), neighbor(cur_slot, 1),
                            i_offer0, i_offer0_cap);
            exp0.push_back(g);
            charge(g);
            i_offer0_valid = 1'b1;
        end
        if (use1) begin
            make_offer(i_offer1, i_offer1_cap);
            g = relay_grant(model_avail, neighbor(cur_slot, 0), neighbor(cur_slot, 1),
                            i_offer1, i_offer1_cap);
            exp1.push_back(g);
            charge(g);
            i_offer1_valid = 1'b1;
        end
        @(negedge i_clk);
        i_offer0_valid = 1'b0;
        i_offer1_valid = 1'b0;
    endtask

    task automatic open_case();
        case_err_start = errors;
    endtask

    task automatic close_case(input string name);
        cases++;
        if (errors == case_err_start) begin
            $display("case %0d %-28s ok", cases, name);
        end else begin
            $display("case %0d %-28s FAIL (%0d errors)", cases, name, errors - case_err_start);
        end
    endtask

    task automatic expect_count(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %0d got %0d", $time, what, want, got);
        end
    endtask

    //////////////////////////////
    // relay checker
    //////////////////////////////
    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (o_slot_start) begin
                slot_start_cnt++;
            end
            if (o_relay0_valid) begin
                relay0_cnt++;
                if (exp0.size() == 0) begin
                    errors++;
                    $display("unexpected o_relay0 pulse at %0t", $time);
                end else begin
                    got_exp = exp0.pop_front();
                    checks++;
                    if (o_relay0 !== got_exp) begin
                        errors++;
                        $display("MISMATCH t=%0t o_relay0 expected %h got %h",
                                 $time, got_exp, o_relay0);
                    end
                end
            end
            if (o_relay1_valid) begin
                relay1_cnt++;
                if (exp1.size() == 0) begin
                    errors++;
                    $display("unexpected o_relay1 pulse at %0t", $time);
                end else begin
                    got_exp = exp1.pop_front();
                    checks++;
                    if (o_relay1 !== got_exp) begin
                        errors++;
                        $display("MISMATCH t=%0t o_relay1 expected %h got %h",
                                 $time, got_exp, o_relay1);
                    end
                end
            end
        end
    end

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_ctrl_valid = 1'b0;
        i_ctrl_data  = '0;
        i_ctrl_last  = 1'b0;
        i_ctrl_keep  = '0;
        i_ctrl_user  = 1'b0;
        i_check_queue_resp_ready = 1'b0;
        i_local_queue_size   = '0;
        i_unlocal_queue_size = '0;
        i_offer0 = '0;
        i_offer0_cap = '0;
        i_offer0_valid = 1'b0;
        i_offer1 = '0;
        i_offer1_cap = '0;
        i_offer1_valid = 1'b0;
        model_avail = '0;
        cur_slot = 0;
        repeat (5) @(negedge i_clk);
        i_rst = 1'b0;

        open_case();
        @(negedge i_clk);
        expect_count("o_check_queue_req_valid", o_check_queue_req_valid, 0);
        expect_count("o_slot_start", o_slot_start, 0);
        expect_count("o_relay0_valid", o_relay0_valid, 0);
        expect_count("o_relay1_valid", o_relay1_valid, 0);
        close_case("reset values");

        open_case();
        send_frame(vlb_pkg::slot_id_type, 0);
        run_snapshot(0);
        expect_count("o_slot_start pulses", slot_start_cnt, 1);
        expect_count("o_slot_id", o_slot_id, 0);
        // a frame of another type must be ignored
        send_frame(16'h1234, 1);
        repeat (8) @(negedge i_clk);
        expect_count("o_slot_start pulses", slot_start_cnt, 1);
        expect_count("o_check_queue_req_valid", o_check_queue_req_valid, 0);
        close_case("slot frame and snapshot");

        open_case();
        pulse_offers(1, 0);
        wait_level(2, 1'b1, 10, "o_relay0_valid");
        repeat (4) @(negedge i_clk);
        expect_count("o_relay0 pulses", relay0_cnt, 1);
        close_case("single offer slot 0");

        open_case();
        pulse_offers(1, 0);
        wait_level(2, 1'b1, 10, "o_relay0_valid");
        repeat (4) @(negedge i_clk);
        expect_count("o_relay0 pulses", relay0_cnt, 2);
        close_case("second offer charged");

        open_case();
        pulse_offers(1, 1);
        wait_level(2, 1'b1, 10, "o_relay0_valid");
        if (o_relay1_valid || relay1_cnt != 0) begin
            errors++;
            $display("o_relay1 pulsed before o_relay0 at %0t", $time);
        end
        wait_level(3, 1'b1, 10, "o_relay1_valid");
        repeat (4) @(negedge i_clk);
        expect_count("o_relay1 pulses", relay1_cnt, 1);
        close_case("both uplinks together");

        open_case();
        send_frame(vlb_pkg::slot_id_type, 1);
        run_snapshot(1);
        expect_count("o_slot_id", o_slot_id, 1);
        pulse_offers(1, 0);
        wait_level(2, 1'b1, 10, "o_relay0_valid");
        pulse_offers(0, 1);
        wait_level(3, 1'b1, 10, "o_relay1_valid");
        repeat (6) @(negedge i_clk);
        expect_count("pending relays", exp0.size() + exp1.size(), 0);
        close_case("slot 1 neighbors");

        $display("%0d cases, %0d checks, %0d errors", cases, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: hw/queue_snapshot.sv
`timescale 1ns/1ns

module queue_snapshot (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_slot_start,
    input  logic               i_check_queue_resp_ready,
    input  vlb_pkg::size_vec_t i_local_queue_size,
    input  vlb_pkg::size_vec_t i_unlocal_queue_size,
    input  vlb_pkg::size_vec_t i_grant,
    input  logic               i_grant_valid,
    output logic               o_check_queue_req_valid,
    output logic               o_snapshot,
    output vlb_pkg::size_vec_t o_avail
);

    logic [2:0]         resp_sync;
    logic               snap_d;
    vlb_pkg::size_vec_t local_q;
    vlb_pkg::size_vec_t unlocal_q;

    //////////////////////////////
    // request / ready level pair
    //////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_check_queue_req_valid <= 1'b0;
        end else if (resp_sync[2]) begin
            o_check_queue_req_valid <= 1'b0;
        end else if (i_slot_start) begin
            o_check_queue_req_valid <= 1'b1;
        end
    end

    // ready comes from the controller clock domain
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            resp_sync <= 3'b000;
            snap_d    <= 1'b0;
        end else begin
            resp_sync <= {resp_sync[1:0], i_check_queue_resp_ready};
            snap_d    <= o_snapshot;
        end
    end

    // rising edge of the synchronized ready
    assign o_snapshot = resp_sync[1] && !resp_sync[2];

    always_ff @(posedge i_clk) begin
        if (o_snapshot) begin
            local_q   <= i_local_queue_size;
            unlocal_q <= i_unlocal_queue_size;
        end
    end

    //////////////////////////////
    // availability ledger
    //////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_avail <= '0;
        end else if (snap_d) begin
            for (int t = 0; t < vlb_pkg::tor_num; t++) begin
                o_avail[t] <= vlb_pkg::slot_max_pkt - local_q[t] - unlocal_q[t];
            end
        end else if (i_grant_valid) begin
            // every relay grant is charged here
            for (int t = 0; t < vlb_pkg::tor_num; t++) begin
                o_avail[t] <= o_avail[t] - i_grant[t];
            end
        end
    end

endmodule

// File: hw/relay_allocator.sv
`timescale 1ns/1ns

module relay_allocator (
    input  logic               i_clk,
    input  logic               i_rst,
    input  vlb_pkg::size_vec_t i_offer0,
    input  vlb_pkg::size_t     i_offer0_cap,
    input  logic               i_offer0_valid,
    input  vlb_pkg::size_vec_t i_offer1,
    input  vlb_pkg::size_t     i_offer1_cap,
    input  logic               i_offer1_valid,
    input  vlb_pkg::size_vec_t i_avail,
    input  vlb_pkg::tor_t      i_next_even,
    input  vlb_pkg::tor_t      i_next_odd,
    output vlb_pkg::size_vec_t o_relay0,
    output logic               o_relay0_valid,
    output vlb_pkg::size_vec_t o_relay1,
    output logic               o_relay1_valid,
    output vlb_pkg::size_vec_t o_grant,
    output logic               o_grant_valid
);

    vlb_pkg::size_vec_t pend0_offer;
    vlb_pkg::size_vec_t pend1_offer;
    vlb_pkg::size_t     pend0_cap;
    vlb_pkg::size_t     pend1_cap;
    logic [1:0]         pend_valid;
    vlb_pkg::size_vec_t work_offer;
    vlb_pkg::size_t     work_cap;
    logic               busy;
    logic               calc;
    logic               sel;
    logic               take0;
    logic               take1;
    vlb_pkg::size_t     g0;
    vlb_pkg::size_t     g1;
    vlb_pkg::size_vec_t grant_d;

    function automatic vlb_pkg::size_t min3(input vlb_pkg::size_t a,
                                            input vlb_pkg::size_t b,
                                            input vlb_pkg::size_t c);
        vlb_pkg::size_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    //////////////////////////////
    // pending offers
    //////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_offer0_valid) begin
            pend0_offer <= i_offer0;
            pend0_cap   <= i_offer0_cap;
        end
        if (i_offer1_valid) begin
            pend1_offer <= i_offer1;
            pend1_cap   <= i_offer1_cap;
        end
    end

    // fixed priority, uplink 0 first
    assign take0 = !busy && pend_valid[0];
    assign take1 = !busy && !pend_valid[0] && pend_valid[1];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pend_valid <= 2'b00;
            busy       <= 1'b0;
            calc       <= 1'b0;
            sel        <= 1'b0;
        end else begin
            calc <= take0 || take1;
            if (take0) begin
                busy          <= 1'b1;
                sel           <= 1'b0;
                pend_valid[0] <= 1'b0;
            end else if (take1) begin
                busy          <= 1'b1;
                sel           <= 1'b1;
                pend_valid[1] <= 1'b0;
            end else if (o_grant_valid) begin
                // ledger charges on this edge
                busy <= 1'b0;
            end
            // a fresh pulse overwrites and keeps the entry pending
            if (i_offer0_valid) begin
                pend_valid[0] <= 1'b1;
            end
            if (i_offer1_valid) begin
                pend_valid[1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take0) begin
            work_offer <= pend0_offer;
            work_cap   <= pend0_cap;
        end else if (take1) begin
            work_offer <= pend1_offer;
            work_cap   <= pend1_cap;
        end
    end

    //////////////////////////////
    // two-step grant
    //////////////////////////////
    always_comb begin
        g0 = min3(work_offer[i_next_even], work_cap, i_avail[i_next_even]);
        g1 = min3(work_offer[i_next_odd], work_cap - g0, i_avail[i_next_odd]);
        grant_d = '0;
        grant_d[i_next_even] = g0;
        grant_d[i_next_odd]  = g1;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_grant       <= '0;
            o_grant_valid <= 1'b0;
        end else begin
            o_grant_valid <= calc;
            if (calc) begin
                o_grant <= grant_d;
            end
        end
    end

    // route the grant to the served uplink
    assign o_relay0       = sel ? '0 : o_grant;
    assign o_relay1       = sel ? o_grant : '0;
    assign o_relay0_valid = o_grant_valid && !sel;
    assign o_relay1_valid = o_grant_valid && sel;

endmodule

// File: hw/relay_route_table.sv
`timescale 1ns/1ns

module relay_route_table (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_snapshot,
    input  vlb_pkg::slot_t i_slot_id,
    output vlb_pkg::tor_t  o_next_even,
    output vlb_pkg::tor_t  o_next_odd
);

    vlb_pkg::tor_t  even_row [vlb_pkg::slot_num];
    vlb_pkg::tor_t  odd_row  [vlb_pkg::slot_num];
    vlb_pkg::slot_t next_slot;
    logic           snap_d;

    // rotation for this rack
    // OCS0 steps forward by 2s+1, OCS1 steps back by 2s+1
    for (genvar s = 0; s < vlb_pkg::slot_num; s++) begin : g_row
        assign even_row[s] = vlb_pkg::tor_t'(
            (vlb_pkg::my_tor_id + 2 * s + 1) % vlb_pkg::tor_num);
        assign odd_row[s]  = vlb_pkg::tor_t'(
            (vlb_pkg::my_tor_id + vlb_pkg::tor_num - ((2 * s + 1) % vlb_pkg::tor_num))
            % vlb_pkg::tor_num);
    end

    assign next_slot = (i_slot_id == vlb_pkg::slot_t'(vlb_pkg::slot_num - 1)) ?
                       '0 : i_slot_id + 1'b1;

    // load together with the availability ledger
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            snap_d      <= 1'b0;
            o_next_even <= '0;
            o_next_odd  <= '0;
        end else begin
            snap_d <= i_snapshot;
            if (snap_d) begin
                o_next_even <= even_row[next_slot];
                o_next_odd  <= odd_row[next_slot];
            end
        end
    end

endmodule

// File: hw/slot_ctrl_parser.sv
`timescale 1ns/1ns

module slot_ctrl_parser (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_ctrl_valid,
    input  logic [vlb_pkg::ctrl_w-1:0] i_ctrl_data,
    input  logic                       i_ctrl_last,
    output logic                       o_slot_start,
    output vlb_pkg::slot_t             o_slot_id
);

    logic [3:0] beat_cnt;
    logic       slot_hit;

    // beat index inside the current frame
    // saturates so long frames never alias beat 1
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            beat_cnt <= '0;
        end else if (i_ctrl_valid && i_ctrl_last) begin
            beat_cnt <= '0;
        end else if (i_ctrl_valid && (beat_cnt != 4'hf)) begin
            beat_cnt <= beat_cnt + 4'd1;
        end
    end

    // frame type sits in bits 31..16 of beat 1
    assign slot_hit = i_ctrl_valid && (beat_cnt == 4'd1) &&
                      (i_ctrl_data[31:16] == vlb_pkg::slot_id_type);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_slot_start <= 1'b0;
        end else begin
            o_slot_start <= slot_hit;
        end
    end

    // current slot id, held until the next slot frame
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_slot_id <= '0;
        end else if (slot_hit) begin
            o_slot_id <= i_ctrl_data[vlb_pkg::slot_w-1:0];
        end
    end

endmodule

// File: hw/vlb_pkg.sv
package vlb_pkg;

    //////////////////////////////
    // rack and slot geometry
    //////////////////////////////
    localparam int unsigned tor_num  = 8;
    localparam int unsigned tor_w    = 3;
    localparam int unsigned slot_num = 2;
    localparam int unsigned slot_w   = 1;

    //////////////////////////////
    // identity and limits
    //////////////////////////////
    localparam int unsigned my_tor_id = 0;
    localparam int unsigned size_w    = 32;

    typedef logic [size_w-1:0] size_t;

    // per-destination buffer budget for one slot
    localparam size_t slot_max_pkt = 32'h0004_0000;

    //////////////////////////////
    // controller stream
    //////////////////////////////
    localparam logic [15:0] slot_id_type = 16'hff03;
    localparam int unsigned ctrl_w       = 64;
    localparam int unsigned keep_w       = 8;

    // one entry per destination rack
    typedef size_t [tor_num-1:0] size_vec_t;

    typedef logic [tor_w-1:0]  tor_t;
    typedef logic [slot_w-1:0] slot_t;

endpackage

// File: hw/vlb_top.sv
`timescale 1ns/1ns

module vlb_top (
    input  logic                       i_clk,
    input  logic                       i_rst,
    // controller stream
    input  logic                       i_ctrl_valid,
    input  logic [vlb_pkg::ctrl_w-1:0] i_ctrl_data,
    input  logic                       i_ctrl_last,
    input  logic [vlb_pkg::keep_w-1:0] i_ctrl_keep,
    input  logic                       i_ctrl_user,
    // queue snapshot
    input  logic                       i_check_queue_resp_ready,
    input  vlb_pkg::size_vec_t         i_local_queue_size,
    input  vlb_pkg::size_vec_t         i_unlocal_queue_size,
    output logic                       o_check_queue_req_valid,
    // uplink 0
    input  vlb_pkg::size_vec_t         i_offer0,
    input  vlb_pkg::size_t             i_offer0_cap,
    input  logic                       i_offer0_valid,
    output vlb_pkg::size_vec_t         o_relay0,
    output logic                       o_relay0_valid,
    // uplink 1
    input  vlb_pkg::size_vec_t         i_offer1,
    input  vlb_pkg::size_t             i_offer1_cap,
    input  logic                       i_offer1_valid,
    output vlb_pkg::size_vec_t         o_relay1,
    output logic                       o_relay1_valid,
    // slot
    output logic                       o_slot_start,
    output vlb_pkg::slot_t             o_slot_id
);

    logic               snapshot;
    vlb_pkg::size_vec_t avail;
    vlb_pkg::size_vec_t grant;
    logic               grant_valid;
    vlb_pkg::tor_t      next_even;
    vlb_pkg::tor_t      next_odd;

    slot_ctrl_parser u_parser (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ctrl_valid (i_ctrl_valid),
        .i_ctrl_data  (i_ctrl_data),
        .i_ctrl_last  (i_ctrl_last),
        .o_slot_start (o_slot_start),
        .o_slot_id    (o_slot_id)
    );

    queue_snapshot u_snapshot (
        .i_clk                    (i_clk),
        .i_rst                    (i_rst),
        .i_slot_start             (o_slot_start),
        .i_check_queue_resp_ready (i_check_queue_resp_ready),
        .i_local_queue_size       (i_local_queue_size),
        .i_unlocal_queue_size     (i_unlocal_queue_size),
        .i_grant                  (grant),
        .i_grant_valid            (grant_valid),
        .o_check_queue_req_valid  (o_check_queue_req_valid),
        .o_snapshot               (snapshot),
        .o_avail                  (avail)
    );

    relay_route_table u_route (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_snapshot  (snapshot),
        .i_slot_id   (o_slot_id),
        .o_next_even (next_even),
        .o_next_odd  (next_odd)
    );

    relay_allocator u_alloc (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_offer0       (i_offer0),
        .i_offer0_cap   (i_offer0_cap),
        .i_offer0_valid (i_offer0_valid),
        .i_offer1       (i_offer1),
        .i_offer1_cap   (i_offer1_cap),
        .i_offer1_valid (i_offer1_valid),
        .i_avail        (avail),
        .i_next_even    (next_even),
        .i_next_odd     (next_odd),
        .o_relay0       (o_relay0),
        .o_relay0_valid (o_relay0_valid),
        .o_relay1       (o_relay1),
        .o_relay1_valid (o_relay1_valid),
        .o_grant        (grant),
        .o_grant_valid  (grant_valid)
    );

endmodule
